//--- verilog/cart_consts.svh
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

`define CART_SNES_ADDR_W 24   // Console address bus
`define CART_ROM_ADDR_W 23    // 16-bit ROM word address
`define CART_BYTE_W 8

////////////////////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////////////////////

// Extra cycles an MCU access keeps the ROM bus
`define CART_ROM_CYCLE_LEN 7

// Roughly 1 ms of CLK2 with no CPU clock
`define CART_DEAD_TIMEOUT 96000

// Taps in the address/data delay line
`define CART_SYNC_DEPTH 7

`endif

//--- verilog/cart_pkg.sv
`include "cart_consts.svh"

package cart_pkg;

  typedef enum logic {
    MAP_LOROM = 1'b0,
    MAP_HIROM = 1'b1
  } mapper_e;

  typedef struct packed {
    mapper_e                      mapper;
    logic [`CART_SNES_ADDR_W-1:0] rom_mask;  // Byte address mask, sets ROM size
  } cart_cfg_t;

  // Raw console strobes, read/write/ROMSEL are active low
  typedef struct packed {
    logic read_n;
    logic write_n;
    logic cpu_clk;
    logic romsel_n;
  } snes_ctl_t;

  // Filtered levels plus one-cycle edge events
  typedef struct packed {
    logic read_n;
    logic write_n;
    logic cpu_clk;
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
  } snes_evt_t;

  typedef struct packed {
    logic [`CART_SNES_ADDR_W-1:0] addr;
    logic                         write;
    logic [`CART_BYTE_W-1:0]      wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [`CART_BYTE_W-1:0] rdata;
  } mcu_rsp_t;

  typedef struct packed {
    logic                         hit;
    logic [`CART_SNES_ADDR_W-1:0] addr;
  } rom_map_t;

  // One-hot arbiter states
  typedef enum logic [4:0] {
    ARB_IDLE    = 5'b00001,
    ARB_RD_ADDR = 5'b00010,
    ARB_RD_END  = 5'b00100,
    ARB_WR_ADDR = 5'b01000,
    ARB_WR_END  = 5'b10000
  } arb_state_e;

endpackage

//--- verilog/snes_bus_sync.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module snes_bus_sync #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     CLK2,
  input  logic     arst_n,
  input  payload_t raw,
  output payload_t filtered
);

  payload_t taps [`CART_SYNC_DEPTH];  // taps[0] is the newest sample

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CART_SYNC_DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= raw;
      for (int i = 1; i < `CART_SYNC_DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // A bit must be high in both oldest taps to pass, which drops short glitches
  assign filtered = payload_t'(taps[`CART_SYNC_DEPTH-1] & taps[`CART_SYNC_DEPTH-2]);

endmodule

//--- verilog/snes_strobe_detect.sv
`timescale 1ns/1ps

module snes_strobe_detect (
  input  logic                  CLK2,
  input  logic                  arst_n,
  input  cart_pkg::snes_ctl_t   ctl,
  output cart_pkg::snes_evt_t   evt,
  output logic                  romsel_n
);

  // Bit 0 is the newest sample
  logic [7:0] rd_hist;
  logic [7:0] wr_hist;
  logic [7:0] clk_hist;
  logic [7:0] rs_hist;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_hist  <= '1;  // Strobes idle high
      wr_hist  <= '1;
      clk_hist <= '0;
      rs_hist  <= '1;
    end else begin
      rd_hist  <= {rd_hist[6:0], ctl.read_n};
      wr_hist  <= {wr_hist[6:0], ctl.write_n};
      clk_hist <= {clk_hist[6:0], ctl.cpu_clk};
      rs_hist  <= {rs_hist[6:0], ctl.romsel_n};
    end
  end

  always_comb begin
    evt.read_n  = rd_hist[2] & rd_hist[1];
    evt.write_n = wr_hist[2] & wr_hist[1];
    evt.cpu_clk = clk_hist[2] & clk_hist[1];
    // Old high run followed by a low run
    evt.rd_start    = ((rd_hist[6:1] | rd_hist[7:2]) == 6'b111100);
    // Old low run, newest pair high
    evt.rd_end      = ((rd_hist[6:1] & rd_hist[7:2]) == 6'b000001);
    evt.wr_end      = ((wr_hist[6:1] & wr_hist[7:2]) == 6'b000001);
    evt.cycle_start = ((clk_hist[7:2] & clk_hist[6:1]) == 6'b000011);  // CPU clock rise
    evt.cycle_end   = ((clk_hist[7:2] | clk_hist[6:1]) == 6'b111000);  // CPU clock fall
  end

  assign romsel_n = rs_hist[5] & rs_hist[4];

  // A read cannot open and close on the same sample window
  a_rd_edges_exclusive: assert property (
    @(posedge CLK2) disable iff (!arst_n) !(evt.rd_start && evt.rd_end)
  );

endmodule

//--- verilog/snes_liveness.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module snes_liveness (
  input  logic                CLK2,
  input  logic                arst_n,
  input  cart_pkg::snes_evt_t evt,
  output logic                dead
);

  localparam int CNT_W = $clog2(`CART_DEAD_TIMEOUT + 2);
  localparam logic [CNT_W-1:0] TIMEOUT = CNT_W'(`CART_DEAD_TIMEOUT);

  logic [CNT_W-1:0] low_cnt;  // Cycles since the CPU clock was last high

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      low_cnt <= '0;
    end else if (evt.cpu_clk) begin
      low_cnt <= '0;
    end else if (low_cnt <= TIMEOUT) begin
      low_cnt <= low_cnt + 1'b1;  // Saturates one past the timeout
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dead flag
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead <= 1'b1;  // No console seen yet
    end else if (evt.cpu_clk) begin
      dead <= 1'b0;
    end else if (low_cnt > TIMEOUT) begin
      dead <= 1'b1;
    end
  end

endmodule

//--- verilog/rom_map.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module rom_map (
  input  logic                         CLK2,
  input  logic                         arst_n,
  input  logic [`CART_SNES_ADDR_W-1:0] addr,
  input  logic                         romsel_n,
  input  cart_pkg::cart_cfg_t          cfg,
  output cart_pkg::rom_map_t           map
);

  logic [`CART_SNES_ADDR_W-1:0] lo_addr;
  logic [`CART_SNES_ADDR_W-1:0] hi_addr;
  logic [`CART_SNES_ADDR_W-1:0] sel_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Address translation
  ////////////////////////////////////////////////////////////////////////////

  // LoROM drops A15 and packs 32K pages back to back
  assign lo_addr = {2'b00, addr[22:16], addr[14:0]};

  // HiROM maps 64K banks linearly
  assign hi_addr = {2'b00, addr[21:0]};

  always_comb begin
    if (cfg.mapper == cart_pkg::MAP_HIROM) begin
      sel_addr = hi_addr;
    end else begin
      sel_addr = lo_addr;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      map <= '0;
    end else begin
      map.hit  <= ~romsel_n;                 // ROMSEL active means ROM area
      map.addr <= sel_addr & cfg.rom_mask;   // Mirror into the loaded image
    end
  end

endmodule

//--- verilog/mcu_rom_arbiter.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module mcu_rom_arbiter (
  input  logic                         CLK2,
  input  logic                         arst_n,
  input  logic                         req_valid,
  input  cart_pkg::mcu_req_t           req,
  output logic                         req_ready,
  output logic                         rsp_valid,
  output cart_pkg::mcu_rsp_t           rsp,
  input  cart_pkg::snes_evt_t          evt,
  input  cart_pkg::rom_map_t           map,
  input  logic                         dead,
  input  logic [`CART_BYTE_W-1:0]      rom_byte,
  output cart_pkg::arb_state_e         state,
  output logic [`CART_SNES_ADDR_W-1:0] mcu_addr,
  output logic [`CART_BYTE_W-1:0]      mcu_wdata
);

  localparam int DLY_W = $clog2(`CART_ROM_CYCLE_LEN + 1);

  logic             pending;      // Accepted request waiting or in flight
  logic             pend_write;
  logic             free_strobe;  // Cycle after a non-ROM cycle_start
  logic             free_slot;
  logic [DLY_W-1:0] delay;

  assign free_slot = evt.cycle_end | free_strobe;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= cart_pkg::ARB_IDLE;
      delay       <= '0;
      pending     <= 1'b0;
      req_ready   <= 1'b1;
      rsp_valid   <= 1'b0;
      free_strobe <= 1'b0;
    end else begin
      rsp_valid   <= 1'b0;
      free_strobe <= evt.cycle_start & ~map.hit;
      if (req_valid && req_ready) begin
        pending   <= 1'b1;
        req_ready <= 1'b0;
      end
      if (dead && evt.cpu_clk) begin
        state <= cart_pkg::ARB_IDLE;  // Console woke up, redo the access
      end else begin
        case (state)
          cart_pkg::ARB_IDLE: begin
            if (pending && (free_slot || dead)) begin
              state <= pend_write ? cart_pkg::ARB_WR_ADDR : cart_pkg::ARB_RD_ADDR;
              delay <= DLY_W'(`CART_ROM_CYCLE_LEN);
            end
          end
          cart_pkg::ARB_RD_ADDR, cart_pkg::ARB_WR_ADDR: begin
            delay <= delay - 1'b1;
            if (delay == '0) begin
              state <= (state == cart_pkg::ARB_WR_ADDR) ? cart_pkg::ARB_WR_END
                                                        : cart_pkg::ARB_RD_END;
            end
          end
          cart_pkg::ARB_RD_END, cart_pkg::ARB_WR_END: begin
            state     <= cart_pkg::ARB_IDLE;
            pending   <= 1'b0;
            req_ready <= 1'b1;
            rsp_valid <= 1'b1;
          end
          default: state <= cart_pkg::ARB_IDLE;
        endcase
      end
    end
  end

  // Request payload and read result
  always_ff @(posedge CLK2) begin
    if (req_valid && req_ready) begin
      mcu_addr   <= req.addr;
      mcu_wdata  <= req.wdata;
      pend_write <= req.write;
    end
    if (state == cart_pkg::ARB_RD_ADDR) begin
      rsp.rdata <= rom_byte;  // Last sample before RD_END wins
    end
  end

  a_state_onehot: assert property (@(posedge CLK2) disable iff (!arst_n) $onehot(state));

  a_no_ready_while_pending: assert property (
    @(posedge CLK2) disable iff (!arst_n) pending |-> !req_ready
  );

endmodule

//--- verilog/rom_bus_mux.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module rom_bus_mux (
  input  cart_pkg::arb_state_e         state,
  input  logic [`CART_SNES_ADDR_W-1:0] mcu_addr,
  input  logic [`CART_BYTE_W-1:0]      mcu_wdata,
  input  cart_pkg::rom_map_t           map,
  input  cart_pkg::snes_evt_t          evt,
  input  logic [`CART_BYTE_W-1:0]      snes_data,
  input  logic [2*`CART_BYTE_W-1:0]    rom_rdata,
  output logic [`CART_ROM_ADDR_W-1:0]  rom_addr,
  output logic                         rom_bhe_n,
  output logic                         rom_ble_n,
  output logic                         rom_we_n,
  output logic [2*`CART_BYTE_W-1:0]    rom_wdata,
  output logic                         rom_data_oe,
  output logic [`CART_BYTE_W-1:0]      rom_byte,
  output logic [`CART_BYTE_W-1:0]      snes_data_out,
  output logic                         snes_databus_oe_n,
  output logic                         snes_databus_dir
);

  logic                         mcu_hit;
  logic                         mcu_wr_hit;
  logic                         snes_wr_hit;
  logic [`CART_SNES_ADDR_W-1:0] byte_addr;
  logic [`CART_BYTE_W-1:0]      wr_byte;

  assign mcu_wr_hit  = (state == cart_pkg::ARB_WR_ADDR);
  assign mcu_hit     = mcu_wr_hit | (state == cart_pkg::ARB_RD_ADDR);
  assign snes_wr_hit = map.hit & evt.cpu_clk & ~evt.write_n;  // Console write into ROM

  ////////////////////////////////////////////////////////////////////////////
  // ROM side
  ////////////////////////////////////////////////////////////////////////////

  assign byte_addr = mcu_hit ? mcu_addr : map.addr;
  assign rom_addr  = byte_addr[`CART_SNES_ADDR_W-1:1];
  assign rom_bhe_n = byte_addr[0];   // Even byte sits in the upper lane
  assign rom_ble_n = ~byte_addr[0];

  assign wr_byte     = snes_wr_hit ? snes_data : mcu_wdata;
  assign rom_wdata   = {wr_byte, wr_byte};  // Byte enables pick the lane
  assign rom_we_n    = ~(snes_wr_hit | mcu_wr_hit);
  assign rom_data_oe = ~rom_we_n;

  assign rom_byte = byte_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];

  ////////////////////////////////////////////////////////////////////////////
  // Console side
  ////////////////////////////////////////////////////////////////////////////

  assign snes_data_out     = rom_byte;
  assign snes_databus_oe_n = ~(map.hit & (~evt.read_n | ~evt.write_n));
  assign snes_databus_dir  = ~evt.read_n;  // High drives toward the console

endmodule

//--- verilog/snes_cart_top.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module snes_cart_top (
  input  logic                         CLK2,
  input  logic                         arst_n,
  input  logic [`CART_SNES_ADDR_W-1:0] snes_addr,
  input  logic [`CART_BYTE_W-1:0]      snes_data_in,
  input  cart_pkg::snes_ctl_t          snes_ctl,
  input  cart_pkg::cart_cfg_t          cfg,
  input  logic                         mcu_req_valid,
  input  cart_pkg::mcu_req_t           mcu_req,
  output logic                         mcu_req_ready,
  output logic                         mcu_rsp_valid,
  output cart_pkg::mcu_rsp_t           mcu_rsp,
  output logic [`CART_ROM_ADDR_W-1:0]  rom_addr,
  output logic                         rom_bhe_n,
  output logic                         rom_ble_n,
  output logic                         rom_we_n,
  output logic [2*`CART_BYTE_W-1:0]    rom_wdata,
  output logic                         rom_data_oe,
  input  logic [2*`CART_BYTE_W-1:0]    rom_rdata,
  output logic [`CART_BYTE_W-1:0]      snes_data_out,
  output logic                         snes_databus_oe_n,
  output logic                         snes_databus_dir,
  output logic                         snes_dead
);

  logic [`CART_SNES_ADDR_W-1:0] addr_f;
  logic [`CART_BYTE_W-1:0]      data_f;
  logic                         romsel_n;
  logic [`CART_SNES_ADDR_W-1:0] mcu_addr;
  logic [`CART_BYTE_W-1:0]      mcu_wdata;
  logic [`CART_BYTE_W-1:0]      rom_byte;
  cart_pkg::snes_evt_t          evt;
  cart_pkg::rom_map_t           map;
  cart_pkg::arb_state_e         state;

  snes_bus_sync #(.payload_t(logic [`CART_SNES_ADDR_W-1:0])) u_addr_sync (
    .CLK2(CLK2), .arst_n(arst_n), .raw(snes_addr), .filtered(addr_f)
  );

  snes_bus_sync #(.payload_t(logic [`CART_BYTE_W-1:0])) u_data_sync (
    .CLK2(CLK2), .arst_n(arst_n), .raw(snes_data_in), .filtered(data_f)
  );

  snes_strobe_detect u_strobe (
    .CLK2(CLK2), .arst_n(arst_n), .ctl(snes_ctl), .evt(evt), .romsel_n(romsel_n)
  );

  snes_liveness u_liveness (.CLK2(CLK2), .arst_n(arst_n), .evt(evt), .dead(snes_dead));

  rom_map u_map (
    .CLK2(CLK2), .arst_n(arst_n), .addr(addr_f), .romsel_n(romsel_n), .cfg(cfg), .map(map)
  );

  mcu_rom_arbiter u_arb (
    .CLK2(CLK2), .arst_n(arst_n),
    .req_valid(mcu_req_valid), .req(mcu_req), .req_ready(mcu_req_ready),
    .rsp_valid(mcu_rsp_valid), .rsp(mcu_rsp),
    .evt(evt), .map(map), .dead(snes_dead), .rom_byte(rom_byte),
    .state(state), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata)
  );

  rom_bus_mux u_mux (
    .state(state), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
    .map(map), .evt(evt), .snes_data(data_f), .rom_rdata(rom_rdata),
    .rom_addr(rom_addr), .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n),
    .rom_we_n(rom_we_n), .rom_wdata(rom_wdata), .rom_data_oe(rom_data_oe),
    .rom_byte(rom_byte), .snes_data_out(snes_data_out),
    .snes_databus_oe_n(snes_databus_oe_n), .snes_databus_dir(snes_databus_dir)
  );

endmodule

//--- verif/tb_snes_cart.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module tb_snes_cart;

  localparam int MAX_LAT = `CART_ROM_CYCLE_LEN + 4;
  localparam logic [23:0] ROM_MASK = 24'h001FFF;  // 8 KB image, 4096 words
  localparam logic [23:0] MAP_MASK = 24'h1FFFFF;  // 2 MB window, keeps bank bits visible

  logic                  CLK2;
  logic                  arst_n;
  logic [23:0]           snes_addr;
  logic [7:0]            snes_data_in;
  cart_pkg::snes_ctl_t   snes_ctl;
  cart_pkg::cart_cfg_t   cfg;
  logic                  mcu_req_valid;
  cart_pkg::mcu_req_t    mcu_req;
  logic                  mcu_req_ready;
  logic                  mcu_rsp_valid;
  cart_pkg::mcu_rsp_t    mcu_rsp;
  logic [22:0]           rom_addr;
  logic                  rom_bhe_n;
  logic                  rom_ble_n;
  logic                  rom_we_n;
  logic [15:0]           rom_wdata;
  logic                  rom_data_oe;
  logic [15:0]           rom_rdata;
  logic [7:0]            snes_data_out;
  logic                  snes_databus_oe_n;
  logic                  snes_databus_dir;
  logic                  snes_dead;

  logic [15:0] rom_mem [0:4095];
  logic [7:0]  wrote [int];       // Byte model of MCU writes
  int          wr_addrs [$];
  int          errors;
  int          tests;
  int          err_before;
  int          lat_cnt;
  int          low_cnt;
  logic        chk_reset;
  logic        chk_lat;
  logic        chk_rd;
  logic        chk_live;
  logic        chk_slot;
  logic        exp_valid;
  logic [7:0]  exp_rdata;
  logic [22:0] exp_word;
  logic [7:0]  exp_lane;
  logic        outstanding;
  logic        saw_fall;

  snes_cart_top u_dut (.*);

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////////////////////////////////////////
  // ROM model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] fill_word(int idx);
    logic [22:0] a;
    a = 23'(idx);
    return {a[7:0] ^ a[22:15], a[14:7] ^ 8'h5A};  // Every address bit counts
  endfunction

  always @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 4096; i++) begin
        rom_mem[i] <= fill_word(i);
      end
    end else if (!rom_we_n) begin
      if (!rom_bhe_n) rom_mem[rom_addr[11:0]][15:8] <= rom_wdata[15:8];
      if (!rom_ble_n) rom_mem[rom_addr[11:0]][7:0] <= rom_wdata[7:0];
    end
  end

  assign rom_rdata = rom_mem[rom_addr[11:0]];

  // Cycles since the last MCU transfer, and since the CPU clock went low
  always @(posedge CLK2) begin
    lat_cnt <= (mcu_req_valid && mcu_req_ready) ? 1 : lat_cnt + 1;
    low_cnt <= snes_ctl.cpu_clk ? 0 : low_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge CLK2)
    chk_reset |-> (mcu_req_ready && !mcu_rsp_valid && rom_we_n && !rom_data_oe &&
                   snes_databus_oe_n && snes_dead))
    else begin
      errors++;
      $display("Outputs are not in their reset state after reset");
    end

  a_rsp_data: assert property (@(posedge CLK2) disable iff (!arst_n)
    (mcu_rsp_valid && exp_valid) |-> (mcu_rsp.rdata == exp_rdata))
    else begin
      errors++;
      $display("[ERROR] mcu_rsp got %h expected %h", mcu_rsp.rdata, exp_rdata);
    end

  a_rsp_latency: assert property (@(posedge CLK2) disable iff (!arst_n)
    (mcu_rsp_valid && chk_lat) |-> (lat_cnt <= MAX_LAT))
    else begin
      errors++;
      $display("MCU response took %0d cycles, too slow for a dead console", lat_cnt);
    end

  a_rd_addr: assert property (@(posedge CLK2) chk_rd |-> (rom_addr == exp_word))
    else begin
      errors++;
      $display("[ERROR] rom_addr got %h expected %h", rom_addr, exp_word);
    end

  a_rd_data: assert property (@(posedge CLK2) chk_rd |-> (snes_data_out == exp_lane))
    else begin
      errors++;
      $display("[ERROR] snes_data_out got %h expected %h", snes_data_out, exp_lane);
    end

  a_rd_bus: assert property (@(posedge CLK2)
    chk_rd |-> (snes_databus_dir && !snes_databus_oe_n))
    else begin
      errors++;
      $display("Console data bus not driven toward the console during a ROM read");
    end

  a_dead_late: assert property (@(posedge CLK2) disable iff (!arst_n)
    (chk_live && $rose(snes_dead)) |-> (low_cnt > `CART_DEAD_TIMEOUT))
    else begin
      errors++;
      $display("snes_dead rose after only %0d cycles of stopped clock", low_cnt);
    end

  a_slot: assert property (@(posedge CLK2) disable iff (!arst_n)
    (mcu_rsp_valid && chk_slot) |-> saw_fall)
    else begin
      errors++;
      $display("MCU response came before any console cycle end");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Console address to ROM byte address, by the mapper rules
  function automatic logic [23:0] rom_byte_addr(cart_pkg::cart_cfg_t c, logic [23:0] a);
    logic [23:0] m;
    if (c.mapper == cart_pkg::MAP_HIROM) m = {2'b00, a[21:0]};
    else m = {2'b00, a[22:16], a[14:0]};
    return m & c.rom_mask;
  endfunction

  task automatic mcu_access(input logic [23:0] addr, input logic wr, input logic [7:0] wd);
    int n;
    n = 0;
    while (!mcu_req_ready && n < 200) begin
      @(negedge CLK2);
      n++;
    end
    if (!mcu_req_ready) begin
      errors++;
      $display("Timeout waiting for mcu_req_ready");
    end
    @(posedge CLK2);
    mcu_req_valid <= 1'b1;
    mcu_req       <= '{addr: addr, write: wr, wdata: wd};
    @(posedge CLK2);                  // Transfer edge
    mcu_req_valid <= 1'b0;
    outstanding   <= 1'b1;
    n = 0;
    do begin
      @(negedge CLK2);
      n++;
    end while (!mcu_rsp_valid && n < 300);
    if (!mcu_rsp_valid) begin
      errors++;
      $display("Timeout waiting for mcu_rsp_valid at address %h", addr);
    end
    @(posedge CLK2);
    outstanding <= 1'b0;
  endtask

  task automatic wait_dead(input logic level, input int limit);
    int n;
    n = 0;
    while (snes_dead !== level && n < limit) begin
      @(negedge CLK2);
      n++;
    end
    if (snes_dead !== level) begin
      errors++;
      $display("Timeout waiting for snes_dead to become %0d", level);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    err_before = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [23:0] a;
    logic [23:0] b;
    logic [7:0]  d;
    void'($urandom(94));
    errors = 0;
    tests = 0;
    err_before = 0;
    arst_n = 1'b0;
    snes_addr = '0;
    snes_data_in = '0;
    snes_ctl = '{read_n: 1'b1, write_n: 1'b1, cpu_clk: 1'b0, romsel_n: 1'b1};
    cfg = '{mapper: cart_pkg::MAP_LOROM, rom_mask: ROM_MASK};
    mcu_req_valid = 1'b0;
    mcu_req = '0;
    {chk_reset, chk_lat, chk_rd, chk_live, chk_slot} = '0;
    exp_valid = 1'b0;
    exp_rdata = '0;
    exp_word = '0;
    exp_lane = '0;
    outstanding = 1'b0;
    saw_fall = 1'b0;
    repeat (16) @(posedge CLK2);
    arst_n <= 1'b1;

    // 1 reset state
    chk_reset <= 1'b1;
    repeat (3) @(posedge CLK2);
    chk_reset <= 1'b0;
    finish_test("reset state");

    // 2 dead console, writes then reads
    chk_lat <= 1'b1;
    repeat (16) begin
      a = 24'($urandom()) & ROM_MASK;
      d = 8'($urandom());
      if (!wrote.exists(int'(a))) wr_addrs.push_back(int'(a));
      wrote[int'(a)] = d;
      exp_valid <= 1'b0;
      mcu_access(a, 1'b1, d);
    end
    foreach (wr_addrs[i]) begin
      exp_valid <= 1'b1;
      exp_rdata <= wrote[wr_addrs[i]];
      mcu_access(24'(wr_addrs[i]), 1'b0, 8'h00);
    end
    exp_valid <= 1'b0;
    chk_lat   <= 1'b0;
    finish_test("dead console MCU traffic");

    // 3 liveness
    chk_live <= 1'b1;
    repeat (6) begin
      @(posedge CLK2) snes_ctl.cpu_clk <= 1'b1;
      repeat (5) @(posedge CLK2);
      snes_ctl.cpu_clk <= 1'b0;
      repeat (5) @(posedge CLK2);
    end
    wait_dead(1'b0, 50);
    wait_dead(1'b1, `CART_DEAD_TIMEOUT + 100);
    @(posedge CLK2);
    chk_live <= 1'b0;
    finish_test("liveness");

    // 4 console ROM reads, both mappers
    cfg.rom_mask <= MAP_MASK;
    for (int m = 0; m < 2; m++) begin
      cfg.mapper <= cart_pkg::mapper_e'(m);
      repeat (6) begin
        a = 24'($urandom());
        b = rom_byte_addr('{mapper: cart_pkg::mapper_e'(m), rom_mask: MAP_MASK}, a);
        @(posedge CLK2);
        snes_addr <= a;
        snes_ctl.romsel_n <= 1'b0;
        repeat (12) @(posedge CLK2);
        snes_ctl.read_n <= 1'b0;
        repeat (12) @(posedge CLK2);
        exp_word <= b[23:1];
        exp_lane <= b[0] ? rom_mem[b[12:1]][7:0] : rom_mem[b[12:1]][15:8];
        chk_rd   <= 1'b1;
        repeat (4) @(posedge CLK2);
        chk_rd <= 1'b0;
        snes_ctl.read_n   <= 1'b1;
        snes_ctl.romsel_n <= 1'b1;
        repeat (12) @(posedge CLK2);
      end
    end
    finish_test("console ROM reads");

    // 5 MCU read between running console cycles
    cfg.mapper <= cart_pkg::MAP_LOROM;
    snes_addr  <= 24'h808000;
    snes_ctl.romsel_n <= 1'b0;
    fork
      begin
        repeat (24) begin
          @(posedge CLK2);
          snes_ctl.cpu_clk <= 1'b1;
          snes_ctl.read_n  <= 1'b0;
          repeat (16) @(posedge CLK2);
          snes_ctl.cpu_clk <= 1'b0;
          snes_ctl.read_n  <= 1'b1;
          if (outstanding) saw_fall <= 1'b1;  // Raw fall ahead of cycle_end
          repeat (7) @(posedge CLK2);
        end
      end
      begin
        wait_dead(1'b0, 200);
        repeat (20) @(posedge CLK2);
        chk_slot  <= 1'b1;
        exp_valid <= 1'b1;
        exp_rdata <= wrote[wr_addrs[0]];
        mcu_access(24'(wr_addrs[0]), 1'b0, 8'h00);
        chk_slot  <= 1'b0;
        exp_valid <= 1'b0;
      end
    join
    snes_ctl.romsel_n <= 1'b1;
    repeat (4) @(posedge CLK2);
    finish_test("MCU access with console running");

    $display("Tests run %0d, checks failed %0d", tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/snes_bus_sync.sv
verilog/snes_strobe_detect.sv
verilog/snes_liveness.sv
verilog/rom_map.sv
verilog/mcu_rom_arbiter.sv
verilog/rom_bus_mux.sv
verilog/snes_cart_top.sv
verif/tb_snes_cart.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_snes_cart -o tb_snes_cart
	./obj_dir/tb_snes_cart | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
